// File: bench/renameTb.sv
`timescale 1ns/100ps
`default_nettype none

module renameTb;
    import renamePkg::*;

    localparam int robDepth   = 8;
    localparam int issueLimit = 200;   // Cycles one issue may wait for ready
    localparam int drainLimit = 3000;  // Cycles to empty the pipeline
    localparam int tagCount   = 2 ** tagWidth;

    logic                    clk = 1'b0;
    logic                    rst;
    logic                    issueValid;
    logic                    issueReady;
    op_t                     issueOp;
    logic [31:0]             issuePc;
    logic [31:0]             issueImm;
    logic [regNameWidth-1:0] issueRs1;
    logic [regNameWidth-1:0] issueRs2;
    logic [regNameWidth-1:0] issueRd;
    logic                    exeValid;
    nick_t                   exeTag;
    op_t                     exeOp;
    logic [31:0]             exePc;
    logic [31:0]             exeImm;
    nick_t                   exeRs1Tag;
    logic [31:0]             exeRs1Data;
    nick_t                   exeRs2Tag;
    logic [31:0]             exeRs2Data;
    logic                    cplValid;
    nick_t                   cplTag;
    logic [31:0]             cplData;
    logic                    commitValid;
    logic                    commitReady;
    logic [regNameWidth-1:0] commitRd;
    logic [31:0]             commitData;
    logic [31:0]             commitPc;

    logic [31:0] archData [32];       // Settled values as the register file should hold them
    nick_t       archTag  [32];       // Newest pending producer per register
    logic [31:0] progVal  [32];       // Program-order values that execution sees
    op_t         expOp    [tagCount]; // Per-tag record of each issued instruction
    logic [31:0] expPc    [tagCount];
    logic [31:0] expImm   [tagCount];
    nick_t       expRs1Tag  [tagCount];
    logic [31:0] expRs1Data [tagCount];
    nick_t       expRs2Tag  [tagCount];
    logic [31:0] expRs2Data [tagCount];
    logic [31:0] expA [tagCount];     // True operand values
    logic [31:0] expB [tagCount];
    nick_t       exeOrder [$];        // Tags in issue order that execute requests follow
    logic [4:0]  cmRd [$];            // Expected commits with the oldest first
    logic [31:0] cmPc [$];
    logic [31:0] cmData [$];
    nick_t       cmTag [$];
    nick_t       pendTag [$];         // Execution unit work in flight
    int          pendWait [$];
    logic [31:0] pcNext;
    logic        holdCommit;          // Stall the commit port
    int          checks = 0;
    int          errors = 0;
    int          timeouts = 0;
    int          issued = 0;
    int          handshakes = 0;

    renameTop #(.robDepth(robDepth)) u_renameTop (.*);

    always #5 clk = ~clk;

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("error %s: expected %0h, actual %0h", name, expected, actual);
        end
    endtask

    // Result of one instruction from its opcode and true operands
    function automatic logic [31:0] aluRef(input op_t op, input logic [31:0] a,
                                           input logic [31:0] b, input logic [31:0] imm);
        case (op)
            opAdd:   return a + b;
            opSub:   return a - b;
            opAnd:   return a & b;
            opOr:    return a | b;
            opXor:   return a ^ b;
            opSll:   return a << b[4:0];
            opLi:    return imm;
            default: return '0;
        endcase
    endfunction

    // Shadow of rename, retirement and the execute stream sampled mid-cycle
    task automatic trackModel();
        logic        prevValid;
        logic        prevReady;
        logic        renPend;
        logic [4:0]  renRd;
        nick_t       renTag;
        nick_t       t;
        logic [4:0]  rd;
        logic [31:0] data;
        int          nextTag;
        prevValid = 1'b0;
        prevReady = 1'b0;
        renPend   = 1'b0;
        nextTag   = 1;  // Allocation starts at tag 1
        foreach (archData[i]) begin
            archData[i] = '0;
            archTag[i]  = '0;
            progVal[i]  = '0;
        end
        forever begin
            @(negedge clk);
            if (!rst) begin
                // Commit register loaded on the last edge together with the register write
                if (commitValid && (!prevValid || prevReady)) begin
                    if (cmRd.size() == 0) begin
                        errors++;
                        $display("a commit appeared with no instruction outstanding");
                    end else begin
                        rd   = cmRd.pop_front();
                        data = cmData.pop_front();
                        t    = cmTag.pop_front();
                        checkValue("commitRd", rd, commitRd);
                        checkValue("commitPc", cmPc.pop_front(), commitPc);
                        checkValue("commitData", data, commitData);
                        if (rd != 0 && archTag[rd] == t) begin  // Stale tags leave it alone
                            archData[rd] = data;
                            archTag[rd]  = '0;
                        end
                    end
                end
                if (renPend) begin  // Rename from the same edge wins
                    archTag[renRd] = renTag;
                    renPend = 1'b0;
                end
                if (commitValid && commitReady) begin
                    handshakes++;
                end
                if (exeValid) begin
                    if (exeOrder.size() == 0) begin
                        errors++;
                        $display("an execute request came with no issue outstanding");
                    end else begin
                        t = exeOrder.pop_front();
                        checkValue("exeTag", t, exeTag);
                        checkValue("exeOp", expOp[t], exeOp);
                        checkValue("exePc", expPc[t], exePc);
                        checkValue("exeImm", expImm[t], exeImm);
                        checkValue("exeRs1Tag", expRs1Tag[t], exeRs1Tag);
                        checkValue("exeRs1Data", expRs1Data[t], exeRs1Data);
                        checkValue("exeRs2Tag", expRs2Tag[t], exeRs2Tag);
                        checkValue("exeRs2Data", expRs2Data[t], exeRs2Data);
                        pendTag.push_back(t);
                        pendWait.push_back($urandom_range(0, 6));
                    end
                end
                // Issue taken on the coming edge reads the state before it
                if (issueValid && issueReady) begin
                    t = nick_t'(nextTag);
                    expOp[t]      = issueOp;
                    expPc[t]      = issuePc;
                    expImm[t]     = issueImm;
                    expRs1Tag[t]  = archTag[issueRs1];
                    expRs1Data[t] = archData[issueRs1];
                    expRs2Tag[t]  = archTag[issueRs2];
                    expRs2Data[t] = archData[issueRs2];
                    expA[t]       = progVal[issueRs1];
                    expB[t]       = progVal[issueRs2];
                    data = aluRef(issueOp, expA[t], expB[t], issueImm);
                    if (issueRd != 0) begin
                        progVal[issueRd] = data;
                        renPend = 1'b1;
                        renRd   = issueRd;
                        renTag  = t;
                    end
                    cmRd.push_back(issueRd);
                    cmPc.push_back(issuePc);
                    cmData.push_back(data);
                    cmTag.push_back(t);
                    exeOrder.push_back(t);
                    nextTag = (nextTag == robDepth) ? 1 : nextTag + 1;
                    issued++;
                end
            end
            prevValid = commitValid;
            prevReady = commitReady;
        end
    endtask

    // Execution unit returning one due completion per cycle in random order
    task automatic runCompletions();
        int    due [$];
        int    pick;
        nick_t t;
        forever begin
            @(posedge clk);
            #1;
            cplValid = 1'b0;
            due.delete();
            foreach (pendWait[i]) begin
                if (pendWait[i] == 0) begin
                    due.push_back(i);
                end
            end
            if (due.size() > 0) begin
                pick = due[$urandom_range(0, due.size() - 1)];
                t = pendTag[pick];
                cplValid = 1'b1;
                cplTag   = t;
                cplData  = aluRef(expOp[t], expA[t], expB[t], expImm[t]);
                pendTag.delete(pick);
                pendWait.delete(pick);
            end
            foreach (pendWait[i]) begin
                if (pendWait[i] > 0) begin
                    pendWait[i] = pendWait[i] - 1;
                end
            end
        end
    endtask

    task automatic driveCommitReady();
        forever begin
            @(posedge clk);
            #1;
            commitReady = holdCommit ? 1'b0 : ($urandom_range(0, 3) != 0);  // Mostly ready
        end
    endtask

    task automatic setIssue(input op_t op, input logic [4:0] rs1, input logic [4:0] rs2,
                            input logic [4:0] rd, input logic [31:0] imm);
        issueOp  = op;
        issuePc  = pcNext;
        issueImm = imm;
        issueRs1 = rs1;
        issueRs2 = rs2;
        issueRd  = rd;
        pcNext   = pcNext + 32'd4;
    endtask

    task automatic setRandom();
        setIssue(op_t'($urandom_range(0, 6)), $urandom_range(0, 7), $urandom_range(0, 7),
                 $urandom_range(0, 7), $urandom());  // Few registers give many dependencies
    endtask

    // Entered and left 1 ns after a rising edge
    task automatic issueOne(input op_t op, input logic [4:0] rs1, input logic [4:0] rs2,
                            input logic [4:0] rd, input logic [31:0] imm);
        int waited;
        waited = 0;
        setIssue(op, rs1, rs2, rd, imm);
        issueValid = 1'b1;
        @(negedge clk);
        while (!issueReady && waited < issueLimit) begin
            @(negedge clk);
            waited++;
        end
        if (!issueReady) begin
            timeouts++;
            $display("timeout: issue at pc %0h was never accepted", issuePc);
        end
        @(posedge clk);
        #1;
        issueValid = 1'b0;
    endtask

    task automatic waitDrain();
        int waited;
        waited = 0;
        while (handshakes != issued && waited < drainLimit) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (handshakes != issued) begin
            timeouts++;
            $display("timeout: only %0d of %0d instructions committed", handshakes, issued);
        end
    endtask

    // Oldest instruction reaches the held commit port
    task automatic waitForCommit();
        int waited;
        waited = 0;
        while (!commitValid && waited < issueLimit) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (!commitValid) begin
            timeouts++;
            $display("timeout: no commit appeared on the held port");
        end
    endtask

    initial begin
        int   i;
        int   stallAccepted;
        logic took;
        void'($urandom(32'hb7c9f620));
        rst         = 1'b1;
        issueValid  = 1'b0;
        issueOp     = opAdd;
        issuePc     = '0;
        issueImm    = '0;
        issueRs1    = '0;
        issueRs2    = '0;
        issueRd     = '0;
        cplValid    = 1'b0;
        cplTag      = '0;
        cplData     = '0;
        commitReady = 1'b0;
        holdCommit  = 1'b0;
        pcNext      = 32'h1000;
        fork
            trackModel();
            runCompletions();
            driveCommitReady();
        join_none
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
        @(negedge clk);
        checkValue("issueReadyHeld", 0, issueReady);  // One dead cycle after reset
        checkValue("exeValidReset", 0, exeValid);
        checkValue("commitValidReset", 0, commitValid);
        @(negedge clk);
        checkValue("issueReadyArmed", 1, issueReady);
        @(posedge clk);
        #1;

        for (i = 0; i < 32; i += 2) begin  // Every register reads 0 while tags count up
            issueOne(opAdd, i, i + 1, 0, 32'h0);
        end
        waitDrain();

        @(negedge clk);
        holdCommit = 1'b1;  // Older writer retires into the held port, younger waits
        @(posedge clk);
        #1;
        issueOne(opLi, 0, 0, 5, 32'd7);  // Two writers of r5 in flight
        issueOne(opLi, 0, 0, 5, 32'd9);
        issueOne(opAdd, 5, 0, 6, 32'h0);  // Sees the younger tag
        waitForCommit();
        issueOne(opAdd, 5, 0, 8, 32'h0);  // Between the two retirements
        @(negedge clk);
        holdCommit = 1'b0;
        @(posedge clk);
        #1;
        waitDrain();
        issueOne(opAdd, 5, 5, 7, 32'h0);  // Settled r5 with tag 0

        issueOne(opLi, 0, 0, 0, 32'h55);  // Register 0 stays 0
        issueOne(opAdd, 0, 0, 1, 32'h0);
        waitDrain();
        issueOne(opOr, 0, 1, 2, 32'h0);

        for (i = 0; i < 150; i++) begin
            setRandom();
            issueOne(issueOp, issueRs1, issueRs2, issueRd, issueImm);
        end
        waitDrain();

        // Stalled commit port must stop issue once the ROB fills
        @(negedge clk);
        holdCommit = 1'b1;
        @(posedge clk);
        #1;
        stallAccepted = 0;
        setRandom();
        issueValid = 1'b1;
        for (i = 0; i < 40; i++) begin
            @(negedge clk);
            took = issueReady;
            @(posedge clk);
            #1;
            if (took) begin
                stallAccepted++;
                setRandom();
            end
        end
        issueValid = 1'b0;
        @(negedge clk);
        checkValue("issueReadyStalled", 0, issueReady);
        if (stallAccepted > robDepth + 1) begin
            errors++;
            $display("issue kept flowing, %0d accepted while commit was stalled",
                     stallAccepted);
        end
        holdCommit = 1'b0;
        @(posedge clk);
        #1;
        waitDrain();
        checkValue("commitCount", issued, handshakes);
        checkValue("commitQueueLeft", 0, cmRd.size());

        $display("checks %0d, errors %0d, timeouts %0d, issued %0d, committed %0d",
                 checks, errors, timeouts, issued, handshakes);
        if (errors == 0 && timeouts == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: source/commitUnit.sv
`timescale 1ns/100ps
`default_nettype none

module commitUnit (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               headValid,
    input  logic [renamePkg::regNameWidth-1:0] headReg,
    input  renamePkg::nick_t                   headTag,
    input  logic [renamePkg::dataWidth-1:0]    headData,
    input  logic [31:0]                        headPc,
    output logic                               headPop,
    output logic                               retValid,
    output logic [renamePkg::regNameWidth-1:0] retReg,
    output renamePkg::nick_t                   retTag,
    output logic [renamePkg::dataWidth-1:0]    retData,
    output logic                               commitValid,
    input  logic                               commitReady,
    output logic [renamePkg::regNameWidth-1:0] commitRd,
    output logic [renamePkg::dataWidth-1:0]    commitData,
    output logic [31:0]                        commitPc
);
    logic load;  // Head moves into the commit register

    assign load     = headValid && (!commitValid || commitReady);
    assign headPop  = load;  // Slot frees while the port may still wait
    assign retValid = load;
    assign retReg   = headReg;
    assign retTag   = headTag;
    assign retData  = headData;

    always_ff @(posedge clk) begin
        if (rst) begin
            commitValid <= 1'b0;
        end else if (load) begin
            commitValid <= 1'b1;
        end else if (commitReady) begin
            commitValid <= 1'b0;  // Drained with nothing behind it
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            commitRd   <= headReg;
            commitData <= headData;
            commitPc   <= headPc;
        end
    end

    // A finished head waits in the ROB unchanged until it is popped
    headHeld: assert property (@(posedge clk) disable iff (rst)
        headValid && !headPop |=> headValid && $stable(headReg) && $stable(headTag)
            && $stable(headData) && $stable(headPc))
        else $error("ROB head changed before it was popped");

endmodule

`default_nettype wire

// File: source/dispatchIf.sv
`timescale 1ns/100ps
`default_nettype none

// Rename stage to ROB, plus the tag reservation running the other way
interface dispatchIf;
    import renamePkg::*;

    renamed_t entry;       // Renamed instruction
    logic     entryValid;  // Dispatch register full
    logic     entryReady;  // ROB takes entry on this edge
    nick_t    allocTag;    // Tag the next issue receives
    logic     allocAvail;  // ROB has a free tag
    logic     allocTake;   // Issue accepted, allocTag is reserved

    modport regSide (
        output entry,
        output entryValid,
        output allocTake,
        input  entryReady,
        input  allocTag,
        input  allocAvail
    );

    modport robSide (
        input  entry,
        input  entryValid,
        input  allocTake,
        output entryReady,
        output allocTag,
        output allocAvail
    );

endinterface

`default_nettype wire

// File: source/renamePkg.sv
`default_nettype none

package renamePkg;

    localparam int dataWidth    = 32;  // Register data
    localparam int regNameWidth = 5;   // 32 architectural registers
    localparam int robDepth     = 8;   // Default ROB size, tags 1..robDepth
    localparam int tagWidth     = 4;   // Fits robDepth plus tag 0

    // Rename tag, zero means the register holds its settled value
    typedef logic [tagWidth-1:0] nick_t;

    typedef enum logic [3:0] {
        opAdd = 4'd0,  // rs1 + rs2
        opSub = 4'd1,  // rs1 - rs2
        opAnd = 4'd2,
        opOr  = 4'd3,
        opXor = 4'd4,
        opSll = 4'd5,  // rs1 << rs2[4:0]
        opLi  = 4'd6   // rd = imm
    } op_t;

    // Entry handed from rename to the ROB
    typedef struct packed {
        op_t                     op;
        logic [31:0]             pc;
        logic [31:0]             imm;
        logic [regNameWidth-1:0] rd;       // Architectural destination
        nick_t                   rdTag;    // Tag of this instruction
        nick_t                   rs1Tag;   // Producer of rs1, 0 if settled
        logic [dataWidth-1:0]    rs1Data;  // Settled rs1 value
        nick_t                   rs2Tag;
        logic [dataWidth-1:0]    rs2Data;
    } renamed_t;

endpackage

`default_nettype wire

// File: source/renameRegFile.sv
`timescale 1ns/100ps
`default_nettype none

module renameRegFile #(
    parameter int dataWidth = renamePkg::dataWidth
) (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               issueValid,
    output logic                               issueReady,
    input  renamePkg::op_t                     issueOp,
    input  logic [31:0]                        issuePc,
    input  logic [31:0]                        issueImm,
    input  logic [renamePkg::regNameWidth-1:0] issueRs1,
    input  logic [renamePkg::regNameWidth-1:0] issueRs2,
    input  logic [renamePkg::regNameWidth-1:0] issueRd,
    dispatchIf.regSide                         disp,
    input  logic                               retValid,
    input  logic [renamePkg::regNameWidth-1:0] retReg,
    input  renamePkg::nick_t                   retTag,
    input  logic [dataWidth-1:0]               retData
);
    import renamePkg::*;

    localparam int regCount = 2 ** regNameWidth;

    logic [dataWidth-1:0] regData [regCount];  // Settled architectural values
    nick_t                regTag  [regCount];  // Newest producer per register
    logic                 armed;               // Issue held off one cycle after reset
    logic                 accept;              // Issue handshake
    logic                 retHit;              // Retiring tag still newest for its register
    renamed_t             nextEntry;

    // Dispatch register must be free or draining, and a tag must be on offer
    assign issueReady = armed && disp.allocAvail && (!disp.entryValid || disp.entryReady);
    assign accept = issueValid && issueReady;
    assign disp.allocTake = accept;  // Reserve the offered tag
    assign retHit = retValid && (retReg != '0) && (regTag[retReg] == retTag);

    // Sources read the array before this edge's rename, so rs == rd sees the old tag
    always_comb begin
        nextEntry.op      = issueOp;
        nextEntry.pc      = issuePc;
        nextEntry.imm     = issueImm;
        nextEntry.rd      = issueRd;
        nextEntry.rdTag   = disp.allocTag;
        nextEntry.rs1Tag  = regTag[issueRs1];
        nextEntry.rs1Data = regData[issueRs1];
        nextEntry.rs2Tag  = regTag[issueRs2];
        nextEntry.rs2Data = regData[issueRs2];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            armed <= 1'b0;
        end else begin
            armed <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < regCount; i++) begin
                regData[i] <= '0;
                regTag[i]  <= '0;
            end
        end else begin
            if (retHit) begin  // Stale retirements fall through
                regData[retReg] <= retData;
                regTag[retReg]  <= '0;
            end
            if (accept && (issueRd != '0)) begin
                regTag[issueRd] <= disp.allocTag;  // Wins over a same-edge clear
            end
        end
    end

    // Dispatch register holds until the ROB takes it
    always_ff @(posedge clk) begin
        if (rst) begin
            disp.entryValid <= 1'b0;
        end else if (accept) begin
            disp.entryValid <= 1'b1;
        end else if (disp.entryReady) begin
            disp.entryValid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            disp.entry <= nextEntry;
        end
    end

    // A rename always points its register at a real producer
    renameTagLive: assert property (@(posedge clk) disable iff (rst)
        accept |-> (disp.allocTag != '0))
        else $error("issue accepted while tag 0 was on offer");

endmodule

`default_nettype wire

// File: source/renameTop.sv
`timescale 1ns/100ps
`default_nettype none

module renameTop #(
    parameter int robDepth  = renamePkg::robDepth,
    parameter int dataWidth = renamePkg::dataWidth
) (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               issueValid,
    output logic                               issueReady,
    input  renamePkg::op_t                     issueOp,
    input  logic [31:0]                        issuePc,
    input  logic [31:0]                        issueImm,
    input  logic [renamePkg::regNameWidth-1:0] issueRs1,
    input  logic [renamePkg::regNameWidth-1:0] issueRs2,
    input  logic [renamePkg::regNameWidth-1:0] issueRd,
    output logic                               exeValid,
    output renamePkg::nick_t                   exeTag,
    output renamePkg::op_t                     exeOp,
    output logic [31:0]                        exePc,
    output logic [31:0]                        exeImm,
    output renamePkg::nick_t                   exeRs1Tag,
    output logic [dataWidth-1:0]               exeRs1Data,
    output renamePkg::nick_t                   exeRs2Tag,
    output logic [dataWidth-1:0]               exeRs2Data,
    input  logic                               cplValid,
    input  renamePkg::nick_t                   cplTag,
    input  logic [dataWidth-1:0]               cplData,
    output logic                               commitValid,
    input  logic                               commitReady,
    output logic [renamePkg::regNameWidth-1:0] commitRd,
    output logic [dataWidth-1:0]               commitData,
    output logic [31:0]                        commitPc
);
    import renamePkg::*;

    logic                    retValid;  // Retirement write into the register file
    logic [regNameWidth-1:0] retReg;
    nick_t                   retTag;
    logic [dataWidth-1:0]    retData;
    logic                    headValid;  // ROB head ready to retire
    logic [regNameWidth-1:0] headReg;
    nick_t                   headTag;
    logic [dataWidth-1:0]    headData;
    logic [31:0]             headPc;
    logic                    headPop;

    dispatchIf dispBus ();

    renameRegFile #(.dataWidth(dataWidth)) u_renameRegFile (
        .clk, .rst, .issueValid, .issueReady, .issueOp, .issuePc, .issueImm,
        .issueRs1, .issueRs2, .issueRd, .disp(dispBus.regSide),
        .retValid, .retReg, .retTag, .retData
    );

    reorderBuffer #(.robDepth(robDepth), .dataWidth(dataWidth)) u_reorderBuffer (
        .clk, .rst, .disp(dispBus.robSide),
        .exeValid, .exeTag, .exeOp, .exePc, .exeImm,
        .exeRs1Tag, .exeRs1Data, .exeRs2Tag, .exeRs2Data,
        .cplValid, .cplTag, .cplData,
        .headValid, .headReg, .headTag, .headData, .headPc, .headPop
    );

    commitUnit u_commitUnit (
        .clk, .rst, .headValid, .headReg, .headTag, .headData, .headPc, .headPop,
        .retValid, .retReg, .retTag, .retData,
        .commitValid, .commitReady, .commitRd, .commitData, .commitPc
    );

endmodule

`default_nettype wire

// File: source/reorderBuffer.sv
`timescale 1ns/100ps
`default_nettype none

module reorderBuffer #(
    parameter int robDepth  = renamePkg::robDepth,
    parameter int dataWidth = renamePkg::dataWidth
) (
    input  logic                               clk,
    input  logic                               rst,
    dispatchIf.robSide                         disp,
    output logic                               exeValid,
    output renamePkg::nick_t                   exeTag,
    output renamePkg::op_t                     exeOp,
    output logic [31:0]                        exePc,
    output logic [31:0]                        exeImm,
    output renamePkg::nick_t                   exeRs1Tag,
    output logic [dataWidth-1:0]               exeRs1Data,
    output renamePkg::nick_t                   exeRs2Tag,
    output logic [dataWidth-1:0]               exeRs2Data,
    input  logic                               cplValid,
    input  renamePkg::nick_t                   cplTag,
    input  logic [dataWidth-1:0]               cplData,
    output logic                               headValid,
    output logic [renamePkg::regNameWidth-1:0] headReg,
    output renamePkg::nick_t                   headTag,
    output logic [dataWidth-1:0]               headData,
    output logic [31:0]                        headPc,
    input  logic                               headPop
);
    import renamePkg::*;

    localparam int ptrWidth = $clog2(robDepth);
    localparam int cntWidth = $clog2(robDepth + 1);

    typedef logic [ptrWidth-1:0] ptr_t;

    logic                    slotBusy [robDepth];  // Entry arrived, not yet popped
    logic                    slotDone [robDepth];  // Result recorded
    logic [regNameWidth-1:0] slotReg  [robDepth];
    logic [31:0]             slotPc   [robDepth];
    logic [dataWidth-1:0]    slotData [robDepth];
    ptr_t                    allocPtr;  // Next slot to reserve
    ptr_t                    tail;      // Next slot to fill
    ptr_t                    head;      // Oldest in-flight slot
    logic [cntWidth-1:0]     reserved;  // Tags out, not yet retired
    logic                    accept;    // Entry handshake
    ptr_t                    cplSlot;

    // Slot index plus one
    function automatic nick_t tagOf(ptr_t slot);
        return nick_t'(slot) + nick_t'(1);
    endfunction

    // Pointers wrap naturally, and tag robDepth must still fit
    if (((robDepth & (robDepth - 1)) != 0) || (robDepth >= 2 ** tagWidth)) begin : gDepthCheck
        $error("robDepth must be a power of two below 2**tagWidth");
    end

    assign accept          = disp.entryValid && disp.entryReady;
    assign disp.entryReady = !slotBusy[tail];  // Reserved slot is normally free already
    assign disp.allocTag   = tagOf(allocPtr);
    assign disp.allocAvail = reserved != cntWidth'(robDepth);
    assign cplSlot         = ptr_t'(cplTag - nick_t'(1));

    always_ff @(posedge clk) begin
        if (rst) begin
            allocPtr <= '0;
            tail     <= '0;
            head     <= '0;
            reserved <= '0;
        end else begin
            if (disp.allocTake) begin
                allocPtr <= allocPtr + 1'b1;
            end
            if (accept) begin
                tail <= tail + 1'b1;
            end
            if (headPop) begin
                head <= head + 1'b1;
            end
            case ({disp.allocTake, headPop})
                2'b10:   reserved <= reserved + 1'b1;
                2'b01:   reserved <= reserved - 1'b1;
                default: reserved <= reserved;  // Both or neither
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < robDepth; i++) begin
                slotBusy[i] <= 1'b0;
                slotDone[i] <= 1'b0;
            end
        end else begin
            if (accept) begin
                slotBusy[tail] <= 1'b1;
                slotDone[tail] <= 1'b0;
            end
            if (cplValid) begin
                slotDone[cplSlot] <= 1'b1;  // Out of order
            end
            if (headPop) begin
                slotBusy[head] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            slotReg[tail] <= disp.entry.rd;
            slotPc[tail]  <= disp.entry.pc;
        end
        if (cplValid) begin
            slotData[cplSlot] <= cplData;
        end
    end

    // Execute request, one cycle after the entry lands
    always_ff @(posedge clk) begin
        if (rst) begin
            exeValid <= 1'b0;
        end else begin
            exeValid <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            exeTag     <= disp.entry.rdTag;
            exeOp      <= disp.entry.op;
            exePc      <= disp.entry.pc;
            exeImm     <= disp.entry.imm;
            exeRs1Tag  <= disp.entry.rs1Tag;
            exeRs1Data <= disp.entry.rs1Data;
            exeRs2Tag  <= disp.entry.rs2Tag;
            exeRs2Data <= disp.entry.rs2Data;
        end
    end

    assign headValid = slotBusy[head] && slotDone[head];  // Oldest is finished
    assign headReg   = slotReg[head];
    assign headTag   = tagOf(head);
    assign headData  = slotData[head];
    assign headPc    = slotPc[head];

    // One completion per in-flight entry, never for a free slot
    cplOnBusySlot: assert property (@(posedge clk) disable iff (rst)
        cplValid |-> (cplTag != '0) && slotBusy[cplSlot] && !slotDone[cplSlot])
        else $error("completion for idle or finished slot, tag %0d", cplTag);

    // Rename must have reserved the tail's tag before the entry shows up
    entryHasTag: assert property (@(posedge clk) disable iff (rst)
        accept |-> (reserved != '0) && (disp.entry.rdTag == tagOf(tail)))
        else $error("entry arrived without a reserved tag");

endmodule

`default_nettype wire

// File: src.f
source/renamePkg.sv
source/dispatchIf.sv
source/renameRegFile.sv
source/reorderBuffer.sv
source/commitUnit.sv
source/renameTop.sv
bench/renameTb.sv
